// File: bench/spiBridgeChecker.sv
`timescale 1ns/100ps
`include "spiBridge_defines.svh"

module spiBridgeChecker
(
	input logic iSysClk,
	input logic reset,
	input logic spiSclk,
	input logic spiCs,
	input logic spiMiso,
	input logic ufiActive,
	output int frameCount,
	output int okCount,
	output int failCount
);

	localparam int hdrBits = 56;
	// Cycles allowed for ufiActive to fall after release
	localparam int releaseLimit = 6;

	logic [7:0] expCmd [$];
	logic [31:0] expAdrs [$];
	logic [31:0] expRd [$];

	// ----------------------------------------
	// Expected values from the data file
	// ----------------------------------------
	initial
	begin : loadFile
		int fd;
		int got;
		int lineCount;
		string line;
		logic [7:0] cmdByte;
		logic [31:0] adrs;
		logic [31:0] wd;
		logic [31:0] rd;
		lineCount = 0;
		fd = $fopen("bench/spiBridge_testdata.txt", "r");
		if (fd == 0)
			$display("checker cannot open bench/spiBridge_testdata.txt");
		else
		begin
			while (!$feof(fd) && (lineCount < 256))
			begin
				lineCount++;
				got = $fgets(line, fd);
				if (got > 0)
				begin
					got = $sscanf(line, "%h %h %h %h", cmdByte, adrs, wd, rd);
					if (got == 4)
					begin
						expCmd.push_back(cmdByte);
						expAdrs.push_back(adrs);
						expRd.push_back(rd);
					end
				end
			end
			$fclose(fd);
		end
	end

	function automatic string cmdName(input logic [2:0] code);
		case (code)
			`CMD_CSR_RD: return "CSR read";
			`CMD_CSR_WR: return "CSR write";
			`CMD_UFI_WR: return "UFI write";
			`CMD_UFI_RD: return "UFI read";
			default: return "unknown command";
		endcase
	endfunction

	// ----------------------------------------
	// Pin decoder and comparison
	// ----------------------------------------
	logic sclkQ;
	logic csQ;
	int bitCount;
	int csHighCnt;
	logic [31:0] misoWord;
	logic sawActive;
	logic releaseFlagged;

	always @(posedge iSysClk)
	begin : watch
		int errs;
		int idx;
		logic [2:0] code;
		bit isUfi;
		bit isRd;
		errs = 0;
		if (reset)
		begin
			sclkQ <= 1'b0;
			csQ <= 1'b1;
			bitCount <= 0;
			csHighCnt <= 0;
			releaseFlagged <= 1'b0;
			sawActive <= 1'b0;
			frameCount <= 0;
			okCount <= 0;
			failCount <= 0;
		end
		else
		begin
			sclkQ <= spiSclk;
			csQ <= spiCs;
			if (!spiCs)
			begin
				csHighCnt <= 0;
				releaseFlagged <= 1'b0;
				// Frame start
				if (csQ)
				begin
					bitCount <= 0;
					misoWord <= '0;
					sawActive <= ufiActive;
				end
				else
				begin
					if (ufiActive)
						sawActive <= 1'b1;
					// MISO is taken on the SCLK rise of the data phase
					if (!sclkQ && spiSclk)
					begin
						bitCount <= bitCount + 1;
						if (bitCount >= hdrBits)
							misoWord <= {misoWord[30:0], spiMiso};
					end
				end
			end
			else
			begin
				// Frame end on the chip select rise
				if (!csQ)
				begin
					idx = frameCount;
					if (idx >= expCmd.size())
					begin
						$display("checker saw frame %0d but the data file holds %0d frames",
							idx + 1, expCmd.size());
						errs++;
					end
					else
					begin
						code = expCmd[idx][2:0];
						isUfi = (code == `CMD_UFI_WR) || (code == `CMD_UFI_RD);
						isRd = (code == `CMD_CSR_RD) || (code == `CMD_UFI_RD);
						if (isRd && (misoWord !== expRd[idx]))
						begin
							$display("FAILED at %0d ns: spiMiso read word = %h, expected %h",
								$time, misoWord, expRd[idx]);
							errs++;
						end
						// Transfer-valid follows the length field
						if (sawActive !== isUfi)
						begin
							$display("FAILED at %0d ns: ufiActive seen in frame = %b, expected %b",
								$time, sawActive, isUfi);
							errs++;
						end
					end
					frameCount <= frameCount + 1;
					if (errs == 0)
					begin
						okCount <= okCount + 1;
						$display("frame %0d %s at %h: ok", idx + 1, cmdName(code), expAdrs[idx]);
					end
					else
						$display("frame %0d: %0d check(s) failed", idx + 1, errs);
				end
				if (csHighCnt < 1000)
					csHighCnt <= csHighCnt + 1;
				// Idle bus must settle low
				if ((csHighCnt > releaseLimit) && (ufiActive !== 1'b0) && !releaseFlagged)
				begin
					$display("FAILED at %0d ns: ufiActive with chip select high = %b, expected 0",
						$time, ufiActive);
					releaseFlagged <= 1'b1;
					errs++;
				end
			end
			failCount <= failCount + errs;
		end
	end

endmodule

// File: bench/spiBridgeTb.sv
`timescale 1ns/100ps
`include "spiBridge_defines.svh"

module spiBridgeTb;

	// SCLK runs at one tenth of the system clock
	localparam int sclkHalf = 5;
	localparam int frameBits = 88;
	localparam int maxLines = 256;
	localparam int checkLimit = 400;

	logic iSysClk;
	logic reset;
	logic spiSclk;
	logic spiCs;
	logic spiMosi;
	logic spiMiso;
	logic ufiActive;

	// Counts from the checker
	int frameCount;
	int okCount;
	int failCount;
	bit runError;

	// Frames read from the data file
	logic [7:0] cmdList [$];
	logic [31:0] adrsList [$];
	logic [31:0] wdList [$];

	// ----------------------------------------
	// Clock and instances
	// ----------------------------------------
	initial
	begin
		iSysClk = 1'b0;
		forever #10 iSysClk = ~iSysClk;
	end

	spiBridgeTop u_spiBridgeTop
	(
		.iSysClk (iSysClk),
		.reset (reset),
		.spiSclk (spiSclk),
		.spiCs (spiCs),
		.spiMosi (spiMosi),
		.spiMiso (spiMiso),
		.ufiActive (ufiActive)
	);

	spiBridgeChecker u_spiBridgeChecker
	(
		.iSysClk (iSysClk),
		.reset (reset),
		.spiSclk (spiSclk),
		.spiCs (spiCs),
		.spiMiso (spiMiso),
		.ufiActive (ufiActive),
		.frameCount (frameCount),
		.okCount (okCount),
		.failCount (failCount)
	);

	// Length field is 1 for buffer commands and 0 for CSR commands
	function automatic logic [15:0] lengthFor(input logic [7:0] cmdByte);
		logic [2:0] code;
		code = cmdByte[2:0];
		if ((code == `CMD_UFI_WR) || (code == `CMD_UFI_RD))
			return 16'd1;
		else
			return 16'd0;
	endfunction

	// ----------------------------------------
	// Data file
	// ----------------------------------------
	task automatic readFrames();
		int fd;
		int lineCount;
		int got;
		string line;
		logic [7:0] cmdByte;
		logic [31:0] adrs;
		logic [31:0] wd;
		logic [31:0] rd;
		fd = $fopen("bench/spiBridge_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open bench/spiBridge_testdata.txt");
			runError = 1'b1;
			return;
		end
		lineCount = 0;
		while (!$feof(fd) && (lineCount < maxLines))
		begin
			lineCount++;
			got = $fgets(line, fd);
			// Comment and blank lines do not scan as four fields
			if (got > 0)
			begin
				got = $sscanf(line, "%h %h %h %h", cmdByte, adrs, wd, rd);
				if (got == 4)
				begin
					cmdList.push_back(cmdByte);
					adrsList.push_back(adrs);
					wdList.push_back(wd);
				end
			end
		end
		$fclose(fd);
	endtask

	// ----------------------------------------
	// SPI master in mode 0 with MSB first
	// ----------------------------------------
	task automatic sendFrame(input logic [7:0] cmdByte, input logic [31:0] adrs,
		input logic [31:0] wd);
		logic [frameBits-1:0] bits;
		int bitIdx;
		bits = {cmdByte, adrs, lengthFor(cmdByte), wd};
		@(posedge iSysClk);
		spiCs <= 1'b0;
		// MOSI changes with SCLK low and the slave samples on the rise
		for (bitIdx = frameBits - 1; bitIdx >= 0; bitIdx--)
		begin
			spiSclk <= 1'b0;
			spiMosi <= bits[bitIdx];
			repeat (sclkHalf) @(posedge iSysClk);
			spiSclk <= 1'b1;
			repeat (sclkHalf) @(posedge iSysClk);
		end
		spiSclk <= 1'b0;
		repeat (sclkHalf) @(posedge iSysClk);
		spiCs <= 1'b1;
		spiMosi <= 1'b0;
		// Gap lets ufiActive fall before the next frame
		repeat (3 * sclkHalf) @(posedge iSysClk);
	endtask

	// Checker reports each frame after chip select rises
	task automatic waitForChecker(input int target);
		int cycles;
		cycles = 0;
		while ((frameCount < target) && (cycles < checkLimit))
		begin
			@(posedge iSysClk);
			cycles++;
		end
		if (frameCount < target)
		begin
			$display("timeout: checker did not report frame %0d within %0d cycles",
				target, checkLimit);
			runError = 1'b1;
		end
	endtask

	task automatic finishRun();
		$display("frames sent: %0d, checked: %0d, ok: %0d, failed checks: %0d",
			cmdList.size(), frameCount, okCount, failCount);
		if (!runError && (failCount == 0) && (frameCount == cmdList.size())
			&& (okCount == frameCount))
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin : stimulus
		int idx;
		reset = 1'b1;
		spiSclk = 1'b0;
		spiCs = 1'b1;
		spiMosi = 1'b0;
		runError = 1'b0;
		readFrames();
		if (cmdList.size() == 0)
		begin
			$display("no frames were read from the data file");
			runError = 1'b1;
		end
		repeat (2) @(posedge iSysClk);
		reset <= 1'b0;
		repeat (4) @(posedge iSysClk);
		for (idx = 0; (idx < cmdList.size()) && !runError; idx++)
		begin
			sendFrame(cmdList[idx], adrsList[idx], wdList[idx]);
			waitForChecker(idx + 1);
		end
		finishRun();
	end

endmodule

// File: bench/spiBridge_testdata.txt
# cmd byte (low three bits select), address, write word, expected read word
# writes keep the expected column at zero, reads keep the write column at zero
00 00000005 00000000 00000000
01 00000003 deadbeef 00000000
00 00000003 00000000 deadbeef
03 00000010 12345678 00000000
04 00000010 00000000 00005678
f9 00000007 a5a55a5a 00000000
03 00000007 cafef00d 00000000
00 00000007 00000000 a5a55a5a
04 00000007 00000000 0000f00d

// File: include/spiBridge_defines.svh
`ifndef SPI_BRIDGE_DEFINES_SVH
`define SPI_BRIDGE_DEFINES_SVH

// ----------------------------------------
// Field widths
// ----------------------------------------
`define DATA_WORD_BIT 32
`define DATA_LEN_BIT 16
`define SPI_ADRS_BIT 32
`define USI_ADRS_BIT 16
`define UFI_BUS_WIDTH 16
`define CMD_BIT 3

// ----------------------------------------
// Target sizes
// ----------------------------------------
`define CSR_DEPTH 16
`define UFI_DEPTH 256

// Pin synchronizer depth
`define SCLK_SYNC_STAGES 2

// Command codes in the low bits of the command byte
`define CMD_CSR_RD 3'b000
`define CMD_CSR_WR 3'b001
`define CMD_UFI_WR 3'b011
`define CMD_UFI_RD 3'b100

`endif

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module spiBridgeTb -o spiBridgeSim

./obj_dir/spiBridgeSim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished cleanly"

// File: sources.f
+incdir+include
verilog/spiBridgePkg.sv
verilog/spiSlaveFrame.sv
verilog/spiSignalMux.sv
verilog/csrRegFile.sv
verilog/ufiBufferRam.sv
verilog/spiBridgeTop.sv
bench/spiBridgeChecker.sv
bench/spiBridgeTb.sv

// File: verilog/csrRegFile.sv
`timescale 1ns/100ps
`include "spiBridge_defines.svh"

module csrRegFile import spiBridgePkg::*;
(
	input logic iSysClk,
	input logic reset,
	input usiBus usi,
	output dataWord rd
);

	localparam int csrIdxBit = $clog2(`CSR_DEPTH);

	// ----------------------------------------
	// Register array
	// ----------------------------------------
	dataWord csrReg [`CSR_DEPTH];
	logic [csrIdxBit-1:0] csrIdx;

	// Low address bits pick the register
	assign csrIdx = usi.adrs[csrIdxBit-1:0];

	// Control registers start from zero
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `CSR_DEPTH; i++)
				csrReg[i] <= '0;
		end
		else if (usi.wEd)
		begin
			csrReg[csrIdx] <= usi.wd;
		end
	end

	// Read path is combinational
	assign rd = csrReg[csrIdx];

endmodule

// File: verilog/spiBridgePkg.sv
`include "spiBridge_defines.svh"

package spiBridgePkg;

	// ----------------------------------------
	// Vector types
	// ----------------------------------------
	typedef logic [`DATA_WORD_BIT-1:0] dataWord;
	typedef logic [`SPI_ADRS_BIT-1:0] spiAdrs;
	typedef logic [`DATA_LEN_BIT-1:0] dataLen;
	typedef logic [`USI_ADRS_BIT-1:0] usiAdrs;
	typedef logic [`UFI_BUS_WIDTH-1:0] ufiWord;

	// Low three bits of the command byte
	typedef enum logic [`CMD_BIT-1:0]
	{
		cmdCsrRd = `CMD_CSR_RD,
		cmdCsrWr = `CMD_CSR_WR,
		cmdUfiWr = `CMD_UFI_WR,
		cmdUfiRd = `CMD_UFI_RD
	} spiCmd;

	// Frame decoder states
	typedef enum logic [2:0]
	{
		stIdle,
		stCmd,
		stAdrs,
		stLen,
		stData,
		stDone
	} frameState;

	// ----------------------------------------
	// Bus bundles
	// ----------------------------------------
	// Decoded frame toward the mux
	typedef struct packed
	{
		dataWord rd;
		spiAdrs adrs;
		spiCmd cmd;
		dataLen dLen;
		logic rEd;
	} spiReq;

	// CSR side
	typedef struct packed
	{
		dataWord wd;
		usiAdrs adrs;
		logic wEd;
	} usiBus;

	// Buffer side with cmd high for read
	typedef struct packed
	{
		ufiWord wd;
		spiAdrs adrs;
		logic ed;
		logic vd;
		logic cmd;
	} ufiBus;

endpackage

// File: verilog/spiBridgeTop.sv
`timescale 1ns/100ps
`include "spiBridge_defines.svh"

module spiBridgeTop import spiBridgePkg::*;
(
	input logic iSysClk,
	input logic reset,
	input logic spiSclk,
	input logic spiCs,
	input logic spiMosi,
	output logic spiMiso,
	output logic ufiActive
);

	// ----------------------------------------
	// Internal buses
	// ----------------------------------------
	spiReq req;
	usiBus usi;
	ufiBus ufi;
	dataWord usiRd;
	ufiWord ufiRd;
	dataWord missoData;

	// Serial frame decoder
	spiSlaveFrame u_spiSlaveFrame
	(
		.iSysClk (iSysClk),
		.reset (reset),
		.spiSclk (spiSclk),
		.spiCs (spiCs),
		.spiMosi (spiMosi),
		.spiMiso (spiMiso),
		.missoData (missoData),
		.req (req)
	);

	// Command decode and read data select
	spiSignalMux
	#(
		.pBusAdrsBit (`USI_ADRS_BIT),
		.pUfiBusWidth (`UFI_BUS_WIDTH)
	)
	u_spiSignalMux
	(
		.iSysClk (iSysClk),
		.reset (reset),
		.req (req),
		.usi (usi),
		.ufi (ufi),
		.usiRd (usiRd),
		.ufiRd (ufiRd),
		.missoData (missoData)
	);

	// ----------------------------------------
	// Targets
	// ----------------------------------------
	csrRegFile u_csrRegFile
	(
		.iSysClk (iSysClk),
		.reset (reset),
		.usi (usi),
		.rd (usiRd)
	);

	ufiBufferRam u_ufiBufferRam
	(
		.iSysClk (iSysClk),
		.ufi (ufi),
		.rd (ufiRd)
	);

	// Transfer-valid level brought out for monitoring
	assign ufiActive = ufi.vd;

endmodule

// File: verilog/spiSignalMux.sv
`timescale 1ns/100ps
`include "spiBridge_defines.svh"

module spiSignalMux import spiBridgePkg::*;
#(
	parameter int pBusAdrsBit = `USI_ADRS_BIT,
	parameter int pUfiBusWidth = `UFI_BUS_WIDTH
)
(
	input logic iSysClk,
	input logic reset,
	input spiReq req,
	output usiBus usi,
	output ufiBus ufi,
	input dataWord usiRd,
	input ufiWord ufiRd,
	output dataWord missoData
);

	// One cycle of latency so the command decode lines up with the data

	// ----------------------------------------
	// USI bus
	// ----------------------------------------
	always_ff @(posedge iSysClk)
	begin
		usi.wd <= req.rd;
		usi.adrs <= req.adrs[pBusAdrsBit-1:0];
	end

	// CSR write only
	always_ff @(posedge iSysClk)
	begin
		if (reset)
			usi.wEd <= 1'b0;
		else
			usi.wEd <= req.rEd && (req.cmd == cmdCsrWr);
	end

	// ----------------------------------------
	// UFI bus
	// ----------------------------------------
	always_ff @(posedge iSysClk)
	begin
		ufi.wd <= req.rd[pUfiBusWidth-1:0];
		ufi.adrs <= req.adrs;
	end

	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			ufi.ed <= 1'b0;
			ufi.vd <= 1'b0;
			ufi.cmd <= 1'b1;
		end
		else
		begin
			// Enable for both buffer commands
			ufi.ed <= req.rEd && ((req.cmd == cmdUfiWr) || (req.cmd == cmdUfiRd));
			// Low only for a buffer write
			ufi.cmd <= (req.cmd != cmdUfiWr);
			// Transfer active while a length is held
			ufi.vd <= (req.dLen != '0);
		end
	end

	// ----------------------------------------
	// Read data return
	// ----------------------------------------
	logic rdSelUfi;

	always_ff @(posedge iSysClk)
	begin
		if (reset)
			rdSelUfi <= 1'b0;
		else if (req.rEd)
			rdSelUfi <= (req.cmd == cmdUfiRd);
	end

	// Buffer word is zero-extended
	assign missoData = rdSelUfi ? {{(`DATA_WORD_BIT-pUfiBusWidth){1'b0}}, ufiRd} : usiRd;

	// Only one target is enabled per frame
	assert property (@(posedge iSysClk) disable iff (reset) !(usi.wEd && ufi.ed));

endmodule

// File: verilog/spiSlaveFrame.sv
`timescale 1ns/100ps
`include "spiBridge_defines.svh"

module spiSlaveFrame import spiBridgePkg::*;
(
	input logic iSysClk,
	input logic reset,
	input logic spiSclk,
	input logic spiCs,
	input logic spiMosi,
	output logic spiMiso,
	input dataWord missoData,
	output spiReq req
);

	localparam int syncLast = `SCLK_SYNC_STAGES - 1;

	// ----------------------------------------
	// Pin synchronizers
	// ----------------------------------------
	logic [syncLast:0] sclkSync;
	logic [syncLast:0] csSync;
	logic [syncLast:0] mosiSync;
	logic sclkPrev;

	// Idle levels for mode 0 with chip select released
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			sclkSync <= '0;
			csSync <= '1;
			mosiSync <= '0;
			sclkPrev <= 1'b0;
		end
		else
		begin
			sclkSync <= {sclkSync[syncLast-1:0], spiSclk};
			csSync <= {csSync[syncLast-1:0], spiCs};
			mosiSync <= {mosiSync[syncLast-1:0], spiMosi};
			sclkPrev <= sclkSync[syncLast];
		end
	end

	// SCLK edges in the system clock domain
	logic sclkRise;
	logic sclkFall;
	logic csActive;
	logic mosiBit;

	assign sclkRise = sclkSync[syncLast] & ~sclkPrev;
	assign sclkFall = ~sclkSync[syncLast] & sclkPrev;
	assign csActive = ~csSync[syncLast];
	assign mosiBit = mosiSync[syncLast];

	// ----------------------------------------
	// Frame FSM and bit counter
	// ----------------------------------------
	frameState state;
	logic [4:0] bitCnt;
	logic [4:0] fieldLast;
	logic fieldDone;
	logic isRead;
	dataWord shiftIn;
	dataWord shiftNext;

	// Captured fields
	dataWord rdReg;
	spiAdrs adrsReg;
	spiCmd cmdReg;
	dataLen dLenReg;
	logic rEdReg;

	// Last bit index of the current field
	always_comb
	begin
		case (state)
			stCmd: fieldLast = 5'd7;
			stLen: fieldLast = 5'd15;
			default: fieldLast = 5'd31;
		endcase
	end

	assign fieldDone = sclkRise && (bitCnt == fieldLast);
	assign shiftNext = {shiftIn[30:0], mosiBit};
	assign isRead = (cmdReg == cmdCsrRd) || (cmdReg == cmdUfiRd);

	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			state <= stIdle;
			bitCnt <= '0;
			rEdReg <= 1'b0;
			dLenReg <= '0;
		end
		else
		begin
			rEdReg <= 1'b0;
			// Chip select high ends or aborts the frame
			if (!csActive)
			begin
				state <= stIdle;
				bitCnt <= '0;
				dLenReg <= '0;
			end
			else if (state == stIdle)
			begin
				state <= stCmd;
				bitCnt <= '0;
			end
			else if (sclkRise && (state != stDone))
			begin
				bitCnt <= fieldDone ? 5'd0 : bitCnt + 5'd1;
				if (fieldDone)
				begin
					case (state)
						stCmd: state <= stAdrs;
						stAdrs: state <= stLen;
						stLen:
						begin
							state <= stData;
							dLenReg <= shiftNext[`DATA_LEN_BIT-1:0];
							// Reads strobe early so MISO can be loaded
							rEdReg <= isRead;
						end
						default:
						begin
							state <= stDone;
							rEdReg <= ~isRead;
						end
					endcase
				end
			end
		end
	end

	// Payload shift and field capture
	always_ff @(posedge iSysClk)
	begin
		if (sclkRise)
			shiftIn <= shiftNext;
		if (fieldDone && (state == stCmd))
			cmdReg <= spiCmd'(shiftNext[`CMD_BIT-1:0]);
		if (fieldDone && (state == stAdrs))
			adrsReg <= shiftNext;
		if (fieldDone && (state == stData) && !isRead)
			rdReg <= shiftNext;
	end

	assign req = '{rd: rdReg, adrs: adrsReg, cmd: cmdReg, dLen: dLenReg, rEd: rEdReg};

	// ----------------------------------------
	// MISO shifter
	// ----------------------------------------
	logic [1:0] loadPipe;
	dataWord shiftOut;

	// Read word settles two cycles after the strobe
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			loadPipe <= '0;
			shiftOut <= '0;
		end
		else
		begin
			loadPipe <= {loadPipe[0], rEdReg & isRead};
			if (!csActive)
				shiftOut <= '0;
			else if (loadPipe[1])
				shiftOut <= missoData;
			// Skip the falling edge that precedes the data phase
			else if (sclkFall && (state == stData) && (bitCnt != 5'd0))
				shiftOut <= {shiftOut[30:0], 1'b0};
		end
	end

	assign spiMiso = shiftOut[31];

	// Strobe is a single-cycle pulse
	assert property (@(posedge iSysClk) disable iff (reset) req.rEd |=> !req.rEd);

endmodule

// File: verilog/ufiBufferRam.sv
`timescale 1ns/100ps
`include "spiBridge_defines.svh"

module ufiBufferRam import spiBridgePkg::*;
(
	input logic iSysClk,
	input ufiBus ufi,
	output ufiWord rd
);

	localparam int ufiIdxBit = $clog2(`UFI_DEPTH);

	// ----------------------------------------
	// Buffer storage
	// ----------------------------------------
	ufiWord mem [`UFI_DEPTH];
	logic [ufiIdxBit-1:0] ufiIdx;
	ufiWord rdReg;

	assign ufiIdx = ufi.adrs[ufiIdxBit-1:0];

	// Write on enable with cmd low
	always_ff @(posedge iSysClk)
	begin
		if (ufi.ed && !ufi.cmd)
			mem[ufiIdx] <= ufi.wd;
	end

	// Registered read on enable with cmd high
	always_ff @(posedge iSysClk)
	begin
		if (ufi.ed && ufi.cmd)
			rdReg <= mem[ufiIdx];
	end

	assign rd = rdReg;

	// Enable only inside an active transfer
	assert property (@(posedge iSysClk) ufi.ed |-> ufi.vd);

endmodule
